//--- list.f
+incdir+rtl
rtl/muldiv_pkg.sv
rtl/seq_multiplier.sv
rtl/restoring_divider.sv
rtl/muldiv_result_stage.sv
rtl/muldiv_unit.sv
tb/muldiv_asserts.sv
tb/muldiv_checker.sv
tb/muldiv_tb.sv

//--- run.sh
#!/bin/bash
# Builds the muldiv testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -j 0 --assert --timescale 1ns/100ps \
    --top-module muldiv_tb -f list.f -o muldiv_sim

./obj_dir/muldiv_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q -F '*** FAILED ***' sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi
echo "Simulation finished without failures"

//--- tb/muldiv_tb.sv
`include "muldiv_consts.svh"

module muldiv_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_OPS    = 2000;
    localparam int STEADY_OPS = 400;    // Sent with resp_ready held high.
    localparam int TIMEOUT_NS = (NUM_OPS + 8) * 40 * 4 + 4000;

    logic                     clk;
    logic                     reset;
    logic                     req_valid;
    logic                     req_ready;
    muldiv_pkg::md_req_t      req;
    logic                     resp_valid;
    logic                     resp_ready;
    muldiv_pkg::md_resp_t     resp;
    logic                     stalls_on;
    logic [`MD_TAG_WIDTH-1:0] next_tag;
    logic [31:0]              draw;
    logic [31:0]              stall_draw;
    int                       value_errors;
    int                       other_errors;
    int                       pending;
    int                       reorders;
    int                       checked;
    int                       end_errors;
    int                       assert_fails;
    int                       wait_cycles;

    always #2 clk = ~clk;

    // About one stall cycle in four once stalls are enabled.
    always @(posedge clk) begin
        stall_draw = $urandom;
        resp_ready <= !stalls_on || (stall_draw[1:0] != 2'b00);
    end

    muldiv_unit DUT (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp)
    );

    muldiv_checker u_checker (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req          (req),
        .resp_valid   (resp_valid),
        .resp_ready   (resp_ready),
        .resp         (resp),
        .value_errors (value_errors),
        .other_errors (other_errors),
        .pending      (pending),
        .reorders     (reorders),
        .checked      (checked)
    );

    bind muldiv_unit muldiv_asserts u_asserts (
        .clk        (clk),
        .reset      (reset),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp)
    );

    // One operand in eight is a corner value.
    function automatic logic [31:0] pick_operand();
        logic [31:0] pick;
        pick = $urandom;
        if (pick[2:0] != 3'd0) begin
            return $urandom;
        end
        case (pick[4:3])
            2'd0:    return 32'h0000_0000;
            2'd1:    return 32'h0000_0001;
            2'd2:    return 32'hffff_ffff;
            default: return 32'h8000_0000;
        endcase
    endfunction

    // Holds the request until the DUT takes it.
    task automatic send(input logic [2:0] op, input logic [31:0] a, input logic [31:0] b);
        muldiv_pkg::md_req_t r;
        r.op.raw = op;
        r.a      = a;
        r.b      = b;
        r.tag    = next_tag;
        req_valid <= 1'b1;
        req       <= r;
        @(posedge clk);
        while (!req_ready) begin
            @(posedge clk);
        end
        req_valid <= 1'b0;
        next_tag = next_tag + 1'b1;
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns, %0d operations outstanding",
                 TIMEOUT_NS, pending);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        resp_ready = 1'b1;
        stalls_on  = 1'b0;
        next_tag   = '0;
        end_errors = 0;
        draw       = $urandom(32'hc402d6d3);
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        // Divide by zero behind a long multiply returns first.
        send(3'd0, 32'h1234_5678, 32'h9abc_def0);
        send(3'd4, 32'd100, 32'd0);
        send(3'd4, 32'h8000_0000, 32'hffff_ffff);
        send(3'd6, 32'h8000_0000, 32'hffff_ffff);
        send(3'd5, 32'hdead_beef, 32'd0);
        send(3'd7, 32'hdead_beef, 32'd0);
        send(3'd6, 32'h8000_0000, 32'd0);
        send(3'd3, 32'hffff_ffff, 32'hffff_ffff);

        for (int i = 0; i < NUM_OPS; i++) begin
            if (i == STEADY_OPS) begin
                stalls_on <= 1'b1;
            end
            draw = $urandom;
            send(draw[2:0], pick_operand(), pick_operand());
        end

        wait_cycles = 0;
        @(negedge clk);
        while (pending != 0 && wait_cycles < 200) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (pending != 0) begin
            $display("Error: %0d operations are still outstanding at the end of the run", pending);
            end_errors++;
        end
        if (reorders == 0) begin
            $display("Error: no response ever overtook an older request");
            end_errors++;
        end
        assert_fails = DUT.u_asserts.fail_count;
        $display("Summary: %0d checked, errors %0d value, %0d other, %0d end, %0d assertion",
                 checked, value_errors, other_errors, end_errors, assert_fails);
        if (value_errors + other_errors + end_errors + assert_fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- tb/muldiv_checker.sv
`include "muldiv_consts.svh"

module muldiv_checker (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 req_valid,
    input  logic                 req_ready,
    input  muldiv_pkg::md_req_t  req,
    input  logic                 resp_valid,
    input  logic                 resp_ready,
    input  muldiv_pkg::md_resp_t resp,
    output int                   value_errors,
    output int                   other_errors,
    output int                   pending,
    output int                   reorders,
    output int                   checked
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TAGS = 1 << `MD_TAG_WIDTH;

    logic                busy_tag   [NUM_TAGS];
    logic [`MD_XLEN-1:0] expect_val [NUM_TAGS];
    logic [2:0]          op_of      [NUM_TAGS];
    logic                by_zero    [NUM_TAGS];
    logic                ready_high [NUM_TAGS];  // No stall since the request.
    int                  start_of   [NUM_TAGS];
    int                  order_of   [NUM_TAGS];
    int                  cycle;
    int                  issued;
    int                  last_xfer;

    function automatic string op_name(input logic [2:0] op);
        case (op)
            3'd0:    return "mul";
            3'd1:    return "mulh";
            3'd2:    return "mulhsu";
            3'd3:    return "mulhu";
            3'd4:    return "div";
            3'd5:    return "divu";
            3'd6:    return "rem";
            default: return "remu";
        endcase
    endfunction

    // 64-bit reference for all eight funct3 codes.
    function automatic logic [31:0] expected_result(input logic [2:0] op,
                                                    input logic [31:0] a,
                                                    input logic [31:0] b);
        logic [63:0] a_s;
        logic [63:0] b_s;
        logic [63:0] a_u;
        logic [63:0] b_u;
        logic [63:0] full;
        a_s = {{32{a[31]}}, a};
        b_s = {{32{b[31]}}, b};
        a_u = {32'h0, a};
        b_u = {32'h0, b};
        full = '1;                      // Quotient of a zero divisor.
        case (op)
            3'd0, 3'd3: full = a_u * b_u;
            3'd1:       full = a_s * b_s;
            3'd2:       full = a_s * b_u;
            3'd4:       if (b != '0) full = $signed(a_s) / $signed(b_s);
            3'd5:       if (b != '0) full = a_u / b_u;
            3'd6: begin
                if (b == '0) begin
                    full = a_u;
                end else begin
                    full = $signed(a_s) % $signed(b_s);
                end
            end
            default:    full = (b == '0) ? a_u : a_u % b_u;
        endcase
        if (op == 3'd1 || op == 3'd2 || op == 3'd3) begin
            return full[63:32];
        end
        return full[31:0];
    endfunction

    task automatic record_request();
        logic [`MD_TAG_WIDTH-1:0] tag;
        tag = req.tag;
        if (busy_tag[tag]) begin
            $display("Error: tag %0d was issued again before its response came back", tag);
            other_errors++;
        end else begin
            pending++;
        end
        busy_tag[tag]   = 1'b1;
        expect_val[tag] = expected_result(req.op.raw, req.a, req.b);
        op_of[tag]      = req.op.raw;
        by_zero[tag]    = req.op.raw[2] && (req.b == '0);
        ready_high[tag] = 1'b1;
        start_of[tag]   = cycle;
        order_of[tag]   = issued;
        issued++;
    endtask

    task automatic check_response();
        logic [`MD_TAG_WIDTH-1:0] tag;
        int                       latency;
        int                       want;
        logic                     overtook;
        tag = resp.tag;
        if (!busy_tag[tag]) begin
            $display("Error: a response with tag %0d arrived but no such request is outstanding",
                     tag);
            other_errors++;
        end else begin
            checked++;
            if (resp.result !== expect_val[tag]) begin
                $display("[ERROR] %s expected %h actual %h (tag %0d)",
                         op_name(op_of[tag]), expect_val[tag], resp.result, tag);
                value_errors++;
            end
            latency = cycle - start_of[tag] - 1;
            want    = by_zero[tag] ? 2 : 34;
            if (!op_of[tag][2] && latency == want + 1 && last_xfer == cycle - 1) begin
                want = want + 1;  // Multiply lost arbitration to the divider.
            end
            if (ready_high[tag] && latency != want) begin
                $display("[ERROR] %s latency expected %0d actual %0d (tag %0d)",
                         op_name(op_of[tag]), want, latency, tag);
                value_errors++;
            end
            overtook = 1'b0;
            for (int t = 0; t < NUM_TAGS; t++) begin
                if (busy_tag[t] && order_of[t] < order_of[tag]) begin
                    overtook = 1'b1;
                end
            end
            if (overtook) begin
                reorders++;
            end
            busy_tag[tag] = 1'b0;
            pending--;
        end
        last_xfer = cycle;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            for (int t = 0; t < NUM_TAGS; t++) begin
                busy_tag[t] = 1'b0;
            end
            cycle        = 0;
            issued       = 0;
            last_xfer    = -1;
            value_errors = 0;
            other_errors = 0;
            pending      = 0;
            reorders     = 0;
            checked      = 0;
        end else begin
            cycle++;
            for (int t = 0; t < NUM_TAGS; t++) begin
                if (!resp_ready) begin
                    ready_high[t] = 1'b0;
                end
            end
            if (resp_valid && resp_ready) begin
                check_response();
            end
            if (req_valid && req_ready) begin
                record_request();
            end
        end
    end

endmodule

//--- tb/muldiv_asserts.sv
module muldiv_asserts (
    input logic                 clk,
    input logic                 reset,
    input logic                 req_ready,
    input logic                 resp_valid,
    input logic                 resp_ready,
    input muldiv_pkg::md_resp_t resp
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // A stalled response keeps its valid and its payload.
    resp_held: assert property (@(posedge clk) disable iff (reset)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp))
        else begin
            $error("resp_valid dropped or resp changed while resp_ready was low");
            fail_count++;
        end

    reset_clears_resp: assert property (@(posedge clk) reset |=> !resp_valid)
        else begin
            $error("resp_valid is high in the cycle after reset");
            fail_count++;
        end

    reset_idles_units: assert property (@(posedge clk) reset |=> req_ready)
        else begin
            $error("req_ready is low in the cycle after reset");
            fail_count++;
        end

endmodule

//--- rtl/muldiv_unit.sv
module muldiv_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  muldiv_pkg::md_req_t  req,
    output logic                 resp_valid,
    input  logic                 resp_ready,
    output muldiv_pkg::md_resp_t resp
);

    logic                 is_div;
    logic                 mul_in_valid;
    logic                 mul_in_ready;
    logic                 div_in_valid;
    logic                 div_in_ready;
    logic                 mul_out_valid;
    logic                 mul_out_ready;
    muldiv_pkg::md_resp_t mul_out;
    logic                 div_out_valid;
    logic                 div_out_ready;
    muldiv_pkg::md_resp_t div_out;

    // Steer by funct3 bit 2.
    assign is_div       = req.op.div.is_div;
    assign mul_in_valid = req_valid && !is_div;
    assign div_in_valid = req_valid && is_div;
    assign req_ready    = is_div ? div_in_ready : mul_in_ready;

    seq_multiplier u_mul (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (mul_in_valid),
        .in_ready  (mul_in_ready),
        .in        (req),
        .out_valid (mul_out_valid),
        .out_ready (mul_out_ready),
        .out       (mul_out)
    );

    restoring_divider u_div (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (div_in_valid),
        .in_ready  (div_in_ready),
        .in        (req),
        .out_valid (div_out_valid),
        .out_ready (div_out_ready),
        .out       (div_out)
    );

    muldiv_result_stage u_result (
        .clk        (clk),
        .reset      (reset),
        .mul_valid  (mul_out_valid),
        .mul_ready  (mul_out_ready),
        .mul_resp   (mul_out),
        .div_valid  (div_out_valid),
        .div_ready  (div_out_ready),
        .div_resp   (div_out),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp)
    );

endmodule

//--- rtl/muldiv_result_stage.sv
module muldiv_result_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 mul_valid,
    output logic                 mul_ready,
    input  muldiv_pkg::md_resp_t mul_resp,
    input  logic                 div_valid,
    output logic                 div_ready,
    input  muldiv_pkg::md_resp_t div_resp,
    output logic                 resp_valid,
    input  logic                 resp_ready,
    output muldiv_pkg::md_resp_t resp
);

    logic                 valid_q;
    muldiv_pkg::md_resp_t resp_q;
    logic                 can_load;   // Register empty or draining now.
    logic                 take_div;
    logic                 take_mul;

    always_comb begin
        can_load = !valid_q || resp_ready;
        take_div = can_load && div_valid;               // Divider has priority.
        take_mul = can_load && mul_valid && !div_valid;
    end

    assign div_ready  = take_div;
    assign mul_ready  = take_mul;
    assign resp_valid = valid_q;
    assign resp       = resp_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (can_load) begin
            valid_q <= take_div || take_mul;
        end
    end

    // Output payload, held while resp_ready is low.
    always_ff @(posedge clk) begin
        if (take_div) begin
            resp_q <= div_resp;
        end else if (take_mul) begin
            resp_q <= mul_resp;
        end
    end

endmodule

//--- rtl/restoring_divider.sv
`include "muldiv_consts.svh"

module restoring_divider (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  muldiv_pkg::md_req_t  in,
    output logic                 out_valid,
    input  logic                 out_ready,
    output muldiv_pkg::md_resp_t out
);

    logic                        load_q;      // Sign wrapper setup cycle.
    logic                        busy_q;      // Restoring loop running.
    logic                        done_q;
    logic [`MD_COUNT_WIDTH-1:0]  count_q;

    logic                        rem_q;
    logic                        uns_q;
    logic [`MD_TAG_WIDTH-1:0]    tag_q;
    logic                        neg_quo_q;   // Quotient sign, a xor b.
    logic                        neg_rem_q;   // Remainder follows the dividend.
    logic [`MD_XLEN-1:0]         high_q;      // Partial remainder.
    logic [`MD_XLEN-1:0]         low_q;       // Dividend bits, then quotient bits.
    logic [`MD_XLEN-1:0]         divisor_q;

    logic                        a_neg;
    logic                        b_neg;
    logic [`MD_XLEN-1:0]         a_mag;
    logic [`MD_XLEN-1:0]         b_mag;
    logic                        zero_div;
    logic [`MD_XLEN-1:0]         shifted;
    logic [`MD_XLEN:0]           trial;
    logic                        q_bit;
    logic [`MD_XLEN-1:0]         next_high;
    logic [`MD_XLEN-1:0]         quo;
    logic [`MD_XLEN-1:0]         remv;

    always_comb begin
        a_neg    = !uns_q && low_q[`MD_XLEN-1];
        b_neg    = !uns_q && divisor_q[`MD_XLEN-1];
        a_mag    = a_neg ? -low_q : low_q;
        b_mag    = b_neg ? -divisor_q : divisor_q;
        zero_div = (divisor_q == '0);

        // One restoring step over the shifted partial remainder.
        shifted   = {high_q[`MD_XLEN-2:0], low_q[`MD_XLEN-1]};
        trial     = {1'b0, shifted} - {1'b0, divisor_q};
        q_bit     = high_q[`MD_XLEN-1] || !trial[`MD_XLEN];  // Bit shifted out always fits.
        next_high = q_bit ? trial[`MD_XLEN-1:0] : shifted;     // Restore on zero bit.

        quo  = neg_quo_q ? -low_q : low_q;
        remv = neg_rem_q ? -high_q : high_q;
    end

    assign in_ready   = !(load_q || busy_q || done_q);
    assign out_valid  = done_q;
    assign out.result = rem_q ? remv : quo;
    assign out.tag    = tag_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            load_q  <= 1'b0;
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            count_q <= '0;
        end else begin
            if (in_valid && in_ready) begin
                load_q <= 1'b1;
            end
            if (load_q) begin
                load_q  <= 1'b0;
                count_q <= '0;
                if (zero_div) begin
                    done_q <= 1'b1;  // Skip the loop.
                end else begin
                    busy_q <= 1'b1;
                end
            end
            if (busy_q) begin
                count_q <= count_q + 1'b1;
                if (count_q == {`MD_COUNT_WIDTH{1'b1}}) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
            if (done_q && out_ready) begin
                done_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            rem_q     <= in.op.div.rem;
            uns_q     <= in.op.div.uns;
            tag_q     <= in.tag;
            low_q     <= in.a;
            divisor_q <= in.b;
        end else if (load_q) begin
            if (zero_div) begin
                high_q    <= low_q;               // Remainder is the dividend.
                low_q     <= {`MD_XLEN{1'b1}};    // Quotient all ones.
                neg_quo_q <= 1'b0;
                neg_rem_q <= 1'b0;
            end else begin
                high_q    <= '0;
                low_q     <= a_mag;
                divisor_q <= b_mag;
                neg_quo_q <= a_neg ^ b_neg;
                neg_rem_q <= a_neg;
            end
        end else if (busy_q) begin
            high_q <= next_high;
            low_q  <= {low_q[`MD_XLEN-2:0], q_bit};
        end
    end

endmodule

//--- rtl/seq_multiplier.sv
`include "muldiv_consts.svh"

module seq_multiplier (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  muldiv_pkg::md_req_t  in,
    output logic                 out_valid,
    input  logic                 out_ready,
    output muldiv_pkg::md_resp_t out
);

    logic                        load_q;     // Magnitude setup cycle.
    logic                        busy_q;     // Add-shift loop running.
    logic                        done_q;     // Result waiting for delivery.
    logic [`MD_COUNT_WIDTH-1:0]  count_q;

    logic [1:0]                  sel_q;
    logic [`MD_TAG_WIDTH-1:0]    tag_q;
    logic                        neg_q;      // Product must be negated.
    logic [`MD_XLEN-1:0]         mcand_q;
    logic [2*`MD_XLEN-1:0]       acc_q;      // Partial product over multiplier.

    logic                        a_signed;
    logic                        b_signed;
    logic [`MD_XLEN-1:0]         a_mag;
    logic [`MD_XLEN-1:0]         b_mag;
    logic [`MD_XLEN:0]           sum;
    logic [2*`MD_XLEN-1:0]       product;

    always_comb begin
        a_signed = (sel_q == 2'b01) || (sel_q == 2'b10);  // mulh and mulhsu.
        b_signed = (sel_q == 2'b01);                       // mulh only.
        a_mag    = (a_signed && mcand_q[`MD_XLEN-1]) ? -mcand_q : mcand_q;
        b_mag    = (b_signed && acc_q[`MD_XLEN-1]) ? -acc_q[`MD_XLEN-1:0]
                                                   : acc_q[`MD_XLEN-1:0];
        sum      = {1'b0, acc_q[2*`MD_XLEN-1:`MD_XLEN]} + {1'b0, mcand_q};
        product  = neg_q ? -acc_q : acc_q;  // Final sign fix.
    end

    assign in_ready   = !(load_q || busy_q || done_q);
    assign out_valid  = done_q;
    assign out.result = (sel_q == 2'b00) ? product[`MD_XLEN-1:0]
                                         : product[2*`MD_XLEN-1:`MD_XLEN];
    assign out.tag    = tag_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            load_q  <= 1'b0;
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            count_q <= '0;
        end else begin
            if (in_valid && in_ready) begin
                load_q <= 1'b1;
            end
            if (load_q) begin
                load_q  <= 1'b0;
                busy_q  <= 1'b1;
                count_q <= '0;
            end
            if (busy_q) begin
                count_q <= count_q + 1'b1;
                if (count_q == {`MD_COUNT_WIDTH{1'b1}}) begin  // Last of 32 steps.
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
            if (done_q && out_ready) begin
                done_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            sel_q   <= in.op.mul.prod_sel;
            tag_q   <= in.tag;
            mcand_q <= in.a;
            acc_q   <= {{`MD_XLEN{1'b0}}, in.b};  // Raw operands, converted next cycle.
        end else if (load_q) begin
            mcand_q <= a_mag;
            acc_q   <= {{`MD_XLEN{1'b0}}, b_mag};
            neg_q   <= (a_signed && mcand_q[`MD_XLEN-1]) ^ (b_signed && acc_q[`MD_XLEN-1]);
        end else if (busy_q) begin
            // Add when the current multiplier bit is set, then shift right.
            if (acc_q[0]) begin
                acc_q <= {sum, acc_q[`MD_XLEN-1:1]};
            end else begin
                acc_q <= {1'b0, acc_q[2*`MD_XLEN-1:1]};
            end
        end
    end

endmodule

//--- rtl/muldiv_pkg.sv
`include "muldiv_consts.svh"

package muldiv_pkg;

    // Multiply view of the funct3 code.
    typedef struct packed {
        logic       is_div;    // Low for the multiply group.
        logic [1:0] prod_sel;  // 00 low, 01 high ss, 10 high su, 11 high uu.
    } md_mul_view_t;

    // Divide view of the funct3 code.
    typedef struct packed {
        logic is_div;  // High for the divide group.
        logic rem;     // Remainder wanted instead of quotient.
        logic uns;     // Unsigned operands.
    } md_div_view_t;

    // One funct3 word, decoded differently by each unit.
    typedef union packed {
        logic [2:0]   raw;
        md_mul_view_t mul;
        md_div_view_t div;
    } md_op_u;

    typedef struct packed {
        md_op_u                   op;
        logic [`MD_XLEN-1:0]      a;    // rs1 value.
        logic [`MD_XLEN-1:0]      b;    // rs2 value.
        logic [`MD_TAG_WIDTH-1:0] tag;
    } md_req_t;

    typedef struct packed {
        logic [`MD_XLEN-1:0]      result;
        logic [`MD_TAG_WIDTH-1:0] tag;   // Copied from the request.
    } md_resp_t;

endpackage

//--- rtl/muldiv_consts.svh
`ifndef MULDIV_CONSTS_SVH
`define MULDIV_CONSTS_SVH

// Operand and result width.
`define MD_XLEN 32

// Request tag width, sixteen tags in flight at most.
`define MD_TAG_WIDTH 4

// Iteration counter, counts 32 steps.
`define MD_COUNT_WIDTH 5

`endif
